/* Makefile */
# Verilator flow for the AXI4 memory slave
# Any variable below can be overridden on the command line

VERILATOR	?= verilator
TOP			?= axiMemSlaveTb
FILELIST	?= compile.f
BUILD_DIR	?= obj_dir
VFLAGS		?= --timing --assert
PASS_TEXT	?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
+incdir+rtl
rtl/axiMemPkg.sv
rtl/axiBurstSequencer.sv
rtl/memBank.sv
rtl/axiResponseMerger.sv
rtl/axiMemSlave.sv
verif/clockGen.sv
verif/axiMemSlaveTb.sv

/* rtl/axiBurstSequencer.sv */
/* Takes AW, W and AR one transaction at a time and checks the burst once
   Each beat becomes one bank request, reads also send a tag to the merger */
`include "axiMem_consts.svh"

module axiBurstSequencer (
	input	logic					CLK,
	input	logic					reset,
	input	axiMemPkg::axiAddrReq_t	aw,
	output	logic					awReady,
	input	axiMemPkg::axiAddrReq_t	ar,
	output	logic					arReady,
	input	axiMemPkg::axiWBeat_t	w,
	output	logic					wReady,
	input	logic					beatReady,	// Merger has room for one more read beat
	input	logic					bDone,		// B handshake seen
	output	axiMemPkg::bankReq_t	bankReq,
	output	axiMemPkg::beatTag_t	tag,
	output	axiMemPkg::writeDone_t	writeDone
);
	import axiMemPkg::*;

	seqState_t		state;
	axiAddr_t		curAddr;
	axiAddr_t		nextAddr;
	axiBurst_t		curBurst;
	axiId_t			curId;
	axiResp_t		errResp;	// Decided at address time
	axiLen_t		remaining;	// Beats left after the current one
	axiAddrReq_t	selReq;
	bankReq_t		wrReq;		// Write beat, one cycle after W
	bankSel_t		curBank;
	bankIndex_t		curIndex;
	logic			addrHs;
	logic			wHs;
	logic			rdIssue;

	// Size, burst type and range in one place for AW and AR
	function automatic axiResp_t checkReq(input axiAddrReq_t req);
		if (req.addr >= `MEM_BYTES)
			return DECERR;
		if (req.size != `AXI_SIZE_W'($clog2(`AXI_DATA_W / 8)))
			return SLVERR;		// Only full words
		if (req.burst != INCR && req.burst != FIXED)
			return SLVERR;		// WRAP and reserved
		return OKAY;
	endfunction

	// ------------------------------------------------------------
	// Handshakes
	// ------------------------------------------------------------
	assign awReady	= (state == IDLE) && aw.valid;
	assign arReady	= (state == IDLE) && ar.valid && !aw.valid;	// Writes win
	assign addrHs	= awReady || arReady;
	assign selReq	= aw.valid ? aw : ar;
	assign wReady	= (state == WRITE);
	assign wHs		= wReady && w.valid;
	assign rdIssue	= (state == READ) && beatReady;

	// Bits above 11 drop out here, so INCR wraps inside the 4 KB
	assign curBank	= curAddr[2 +: `BANK_SEL_W];
	assign curIndex	= curAddr[2 + `BANK_SEL_W +: `BANK_INDEX_W];
	assign nextAddr	= (curBurst == FIXED) ? curAddr : curAddr + axiAddr_t'(`AXI_DATA_W / 8);

	always_ff @(posedge CLK) begin
		// Payload, no reset
		if (addrHs) begin
			curId		<= selReq.id;
			curAddr		<= selReq.addr;
			curBurst	<= selReq.burst;
			remaining	<= selReq.len;
			errResp		<= checkReq(selReq);
		end else if (wHs || rdIssue) begin
			curAddr		<= nextAddr;
			remaining	<= remaining - 1'b1;
		end
		wrReq.write		<= (errResp == OKAY);	// Error bursts drain W without writing
		wrReq.bank		<= curBank;
		wrReq.index		<= curIndex;
		wrReq.data		<= w.data;
		wrReq.strb		<= w.strb;
		writeDone.id	<= curId;
		writeDone.resp	<= errResp;

		if (reset) begin
			state			<= IDLE;
			wrReq.valid		<= 1'b0;
			writeDone.valid	<= 1'b0;
		end else begin
			wrReq.valid		<= wHs;
			writeDone.valid	<= wHs && w.last;	// One pulse per burst
			case (state)
				IDLE:	if (addrHs) state <= awReady ? WRITE : READ;
				WRITE:	if (wHs && w.last) state <= WRESP;
				WRESP:	if (bDone) state <= IDLE;	// No new address until B is taken
				READ:	if (rdIssue && remaining == '0) state <= IDLE;
				default:	state <= IDLE;
			endcase
		end
	end

	// Read beats go out combinationally so data lands 3 cycles after AR
	always_comb begin
		bankReq = wrReq;
		if (rdIssue) begin
			bankReq.write	= 1'b0;
			bankReq.bank	= curBank;
			bankReq.index	= curIndex;
			bankReq.data	= '0;
			bankReq.strb	= '0;
			bankReq.valid	= (errResp == OKAY);	// Error beats skip the banks
		end
	end

	assign tag.id		= curId;
	assign tag.bank		= curBank;
	assign tag.resp		= errResp;
	assign tag.last		= (remaining == '0);
	assign tag.valid	= rdIssue;

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	// WREADY opens only right after an accepted AW
	wReadyAfterAw: assert property (@(posedge CLK) disable iff (reset)
		$rose(wReady) |-> $past(awReady));
	// The last tag closes the burst, no stray beat behind it
	lastTagEndsBurst: assert property (@(posedge CLK) disable iff (reset)
		tag.valid && tag.last |=> !tag.valid);

endmodule

/* rtl/axiMemPkg.sv */
/* Types shared by the AXI4 memory slave blocks
   Channel payloads travel as packed structs with their own valid bit */
`include "axiMem_consts.svh"

package axiMemPkg;

	// Plain vectors
	typedef logic [`AXI_ID_W-1:0]		axiId_t;
	typedef logic [`AXI_ADDR_W-1:0]		axiAddr_t;
	typedef logic [`AXI_DATA_W-1:0]		axiData_t;
	typedef logic [`AXI_DATA_W/8-1:0]	axiStrb_t;	// One bit per byte lane
	typedef logic [`AXI_LEN_W-1:0]		axiLen_t;	// Beats minus one
	typedef logic [`BANK_SEL_W-1:0]		bankSel_t;
	typedef logic [`BANK_INDEX_W-1:0]	bankIndex_t;

	typedef enum logic [1:0] {OKAY = 2'b00, EXOKAY = 2'b01, SLVERR = 2'b10, DECERR = 2'b11} axiResp_t;
	typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10, RSVD = 2'b11} axiBurst_t;

	// Sequencer FSM
	typedef enum logic [1:0] {IDLE, WRITE, WRESP, READ} seqState_t;

	// ------------------------------------------------------------
	// Channel structs
	// ------------------------------------------------------------
	typedef struct packed {
		axiId_t		id;
		axiAddr_t	addr;
		axiLen_t	len;
		logic [`AXI_SIZE_W-1:0]	size;
		axiBurst_t	burst;
		logic		valid;
	} axiAddrReq_t;		// AW or AR

	typedef struct packed {
		axiData_t	data;
		axiStrb_t	strb;
		logic		last;
		logic		valid;
	} axiWBeat_t;

	typedef struct packed {
		logic		write;	// Low means read
		bankSel_t	bank;
		bankIndex_t	index;
		axiData_t	data;
		axiStrb_t	strb;
		logic		valid;
	} bankReq_t;		// Broadcast to every bank

	typedef struct packed {
		axiId_t		id;
		bankSel_t	bank;	// Which bank returns the word
		axiResp_t	resp;
		logic		last;
		logic		valid;
	} beatTag_t;

	typedef struct packed {
		axiId_t		id;
		axiResp_t	resp;
		logic		valid;
	} writeDone_t;

	typedef struct packed {
		axiId_t		id;
		axiData_t	data;
		axiResp_t	resp;
		logic		last;
		logic		valid;
	} axiRBeat_t;

	typedef struct packed {
		axiId_t		id;
		axiResp_t	resp;
		logic		valid;
	} axiBResp_t;

endpackage

/* rtl/axiMemSlave.sv */
/* Top of the 4 KB AXI4 slave memory
   Packs the AXI4 ports into channel structs and joins sequencer, banks and merger */
`include "axiMem_consts.svh"

module axiMemSlave (
	input	logic						CLK,
	input	logic						reset,
	// Write address
	input	axiMemPkg::axiId_t			awId,
	input	axiMemPkg::axiAddr_t		awAddr,
	input	axiMemPkg::axiLen_t			awLen,
	input	logic [`AXI_SIZE_W-1:0]		awSize,
	input	axiMemPkg::axiBurst_t		awBurst,
	input	logic						awValid,
	output	logic						awReady,
	// Write data
	input	axiMemPkg::axiData_t		wData,
	input	axiMemPkg::axiStrb_t		wStrb,
	input	logic						wLast,
	input	logic						wValid,
	output	logic						wReady,
	// Write response
	output	axiMemPkg::axiId_t			bId,
	output	axiMemPkg::axiResp_t		bResp,
	output	logic						bValid,
	input	logic						bReady,
	// Read address
	input	axiMemPkg::axiId_t			arId,
	input	axiMemPkg::axiAddr_t		arAddr,
	input	axiMemPkg::axiLen_t			arLen,
	input	logic [`AXI_SIZE_W-1:0]		arSize,
	input	axiMemPkg::axiBurst_t		arBurst,
	input	logic						arValid,
	output	logic						arReady,
	// Read data
	output	axiMemPkg::axiId_t			rId,
	output	axiMemPkg::axiData_t		rData,
	output	axiMemPkg::axiResp_t		rResp,
	output	logic						rLast,
	output	logic						rValid,
	input	logic						rReady
);
	import axiMemPkg::*;

	axiAddrReq_t	awReq, arReq;
	axiWBeat_t		wBeat;
	bankReq_t		bankReq;
	beatTag_t		tag;
	writeDone_t		writeDone;
	axiData_t		rdData [`MEM_BANKS];
	axiRBeat_t		rBeat;
	axiBResp_t		bOut;
	logic			beatReady, bDone;

	assign awReq = '{id: awId, addr: awAddr, len: awLen, size: awSize, burst: awBurst, valid: awValid};
	assign arReq = '{id: arId, addr: arAddr, len: arLen, size: arSize, burst: arBurst, valid: arValid};
	assign wBeat = '{data: wData, strb: wStrb, last: wLast, valid: wValid};

	axiBurstSequencer sequencer (
		.CLK, .reset, .aw(awReq), .awReady, .ar(arReq), .arReady, .w(wBeat), .wReady,
		.beatReady, .bDone, .bankReq, .tag, .writeDone
	);

	// Same request to every bank, each picks its own word
	for (genvar i = 0; i < `MEM_BANKS; i++) begin : banks
		memBank #(.bankNum(bankSel_t'(i))) bank (.CLK, .req(bankReq), .rdData(rdData[i]));
	end

	axiResponseMerger merger (
		.CLK, .reset, .tag, .writeDone, .rdData, .beatReady, .bDone,
		.rBeat, .rReady, .bOut, .bReady
	);

	assign {bId, bResp, bValid} = {bOut.id, bOut.resp, bOut.valid};
	assign {rId, rData, rResp, rLast, rValid} = {rBeat.id, rBeat.data, rBeat.resp, rBeat.last, rBeat.valid};

endmodule

/* rtl/axiMem_consts.svh */
/* Widths and depths of the AXI4 memory slave
   Included by the package and by every RTL file that sizes something */
`ifndef AXI_MEM_CONSTS_SVH
`define AXI_MEM_CONSTS_SVH

// ------------------------------------------------------------
// AXI4 field widths
// ------------------------------------------------------------
`define AXI_ID_W		4		// Transaction ID
`define AXI_ADDR_W		32		// Byte address
`define AXI_DATA_W		32		// One word per beat
`define AXI_LEN_W		8		// Up to 256 beats
`define AXI_SIZE_W		3		// AxSIZE encoding

// ------------------------------------------------------------
// Memory organisation
// ------------------------------------------------------------
`define MEM_BANKS		4		// Word interleaved
`define BANK_DEPTH		256		// Words in each bank
`define BANK_SEL_W		2		// Word address bits 1:0
`define BANK_INDEX_W	8		// Row inside a bank
`define MEM_BYTES		4096	// Whole array, 4 KB

// Read beats waiting for RREADY
`define RFIFO_DEPTH		4

`endif

/* rtl/axiResponseMerger.sv */
/* Lines up read tags with bank data and queues R beats in a 4-entry FIFO
   Also holds the B response until BREADY */
`include "axiMem_consts.svh"

module axiResponseMerger (
	input	logic					CLK,
	input	logic					reset,
	input	axiMemPkg::beatTag_t	tag,
	input	axiMemPkg::writeDone_t	writeDone,
	input	axiMemPkg::axiData_t	rdData [`MEM_BANKS],
	output	logic					beatReady,
	output	logic					bDone,
	output	axiMemPkg::axiRBeat_t	rBeat,
	input	logic					rReady,
	output	axiMemPkg::axiBResp_t	bOut,
	input	logic					bReady
);
	import axiMemPkg::*;

	localparam int PTR_W = $clog2(`RFIFO_DEPTH);

	beatTag_t			tagD;		// Tag one cycle late, matches bank output
	axiRBeat_t			pushBeat;
	axiRBeat_t			fifo [`RFIFO_DEPTH];
	logic [PTR_W-1:0]	wrPtr;
	logic [PTR_W-1:0]	rdPtr;
	logic [PTR_W:0]		count;
	logic				push;
	logic				pop;

	// ------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------
	always_comb begin
		pushBeat.id		= tagD.id;
		pushBeat.data	= (tagD.resp == OKAY) ? rdData[tagD.bank] : '0;	// Error beats carry zero
		pushBeat.resp	= tagD.resp;
		pushBeat.last	= tagD.last;
		pushBeat.valid	= tagD.valid;
	end

	assign push = tagD.valid;
	assign pop	= rBeat.valid && rReady;

	// Two free slots, one of them for the beat still inside a bank
	assign beatReady = (count <= (PTR_W + 1)'(`RFIFO_DEPTH - 2));

	always_comb begin
		rBeat		= fifo[rdPtr];
		rBeat.valid	= (count != '0);
	end

	always_ff @(posedge CLK) begin
		tagD.id		<= tag.id;
		tagD.bank	<= tag.bank;
		tagD.resp	<= tag.resp;
		tagD.last	<= tag.last;
		if (push)
			fifo[wrPtr] <= pushBeat;

		if (reset) begin
			tagD.valid	<= 1'b0;
			wrPtr		<= '0;
			rdPtr		<= '0;
			count		<= '0;
		end else begin
			tagD.valid <= tag.valid;
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Both or neither
			endcase
		end
	end

	// ------------------------------------------------------------
	// Write response
	// ------------------------------------------------------------
	assign bDone = bOut.valid && bReady;	// Releases the sequencer from WRESP

	always_ff @(posedge CLK) begin
		if (writeDone.valid) begin
			bOut.id		<= writeDone.id;
			bOut.resp	<= writeDone.resp;
		end
		if (reset)
			bOut.valid <= 1'b0;
		else if (writeDone.valid)
			bOut.valid <= 1'b1;
		else if (bDone)
			bOut.valid <= 1'b0;
	end

	// Sequencer must respect beatReady across the bank latency
	fifoNoOverflow: assert property (@(posedge CLK) disable iff (reset)
		push && !pop |-> count < (PTR_W + 1)'(`RFIFO_DEPTH));

endmodule

/* rtl/memBank.sv */
/* One word-interleaved bank of the AXI4 memory
   Byte-strobed writes, read data registered one cycle after the request */
`include "axiMem_consts.svh"

module memBank #(
	parameter axiMemPkg::bankSel_t bankNum = '0	// Word address bits 1:0 served here
) (
	input	logic					CLK,
	input	axiMemPkg::bankReq_t	req,
	output	axiMemPkg::axiData_t	rdData
);
	import axiMemPkg::*;

	axiData_t	mem [`BANK_DEPTH];
	logic		hit;

	assign hit = req.valid && (req.bank == bankNum);

	always_ff @(posedge CLK) begin
		if (hit && req.write) begin
			for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
				if (req.strb[b])
					mem[req.index][8*b +: 8] <= req.data[8*b +: 8];	// Unstrobed lanes keep old bytes
			end
		end
		// Output only moves on a read, so it holds for the merger
		if (hit && !req.write)
			rdData <= mem[req.index];
	end

	// A write never lands while this bank's read word is on rdData
	noWriteAfterRead: assert property (@(posedge CLK)
		hit && !req.write |=> !(hit && req.write));

endmodule

/* verif/axiMemSlaveTb.sv */
/* Table-driven testbench for the 4 KB AXI4 memory slave
   Each row is one burst, checked against a reference memory kept here */
`include "axiMem_consts.svh"

module axiMemSlaveTb;
	import axiMemPkg::*;

	typedef struct {
		string					name;
		logic					isWrite;
		axiId_t					id;
		axiAddr_t				addr;
		axiLen_t				len;		// Beats minus one
		axiBurst_t				burst;
		logic [`AXI_SIZE_W-1:0]	size;
		axiStrb_t				strb;		// Same strobe on every beat
		axiResp_t				resp;		// Expected on B or on every R beat
	} testRow_t;

	logic					CLK, reset;
	axiId_t					awId, arId, bId, rId;
	axiAddr_t				awAddr, arAddr;
	axiLen_t				awLen, arLen;
	logic [`AXI_SIZE_W-1:0]	awSize, arSize;
	axiBurst_t				awBurst, arBurst;
	logic					awValid, awReady, arValid, arReady;
	axiData_t				wData, rData;
	axiStrb_t				wStrb;
	logic					wLast, wValid, wReady;
	axiResp_t				bResp, rResp;
	logic					bValid, bReady, rLast, rValid, rReady;

	testRow_t	tests [12];
	axiData_t	refMem [`MEM_BYTES / 4];	// One entry per word
	integer		seed = 32'hf12e;
	int			errors = 0;
	int			checks = 0;
	int			cycles = 0;
	int			limit = 0;

	clockGen clocks (.CLK, .reset);

	axiMemSlave dut (.*);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic coinFlip();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic int wordOf(input axiAddr_t a);
		return int'(a % `MEM_BYTES) / 4;	// Addresses past the end fold back inside
	endfunction

	function automatic axiAddr_t stepAddr(input axiAddr_t a, input axiBurst_t burst);
		return (burst == FIXED) ? a : a + 32'd4;
	endfunction

	task automatic reportProblem(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic checkResp(input string name, input axiResp_t exp, input axiResp_t act);
		checks++;
		if (act !== exp)
			reportProblem($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkId(input string name, input axiId_t exp, input axiId_t act);
		checks++;
		if (act !== exp)
			reportProblem($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkData(input string name, input axiData_t exp, input axiData_t act);
		checks++;
		if (act !== exp)
			reportProblem($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic checkLast(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
			reportProblem($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	// ------------------------------------------------------------
	// Write burst: AW, then W beats, then B under random BREADY
	// ------------------------------------------------------------
	task automatic runWrite(input testRow_t t);
		axiAddr_t	addr;
		axiData_t	data;
		int			beats;
		logic		stalled;
		logic		done;
		addr = t.addr;
		beats = int'(t.len) + 1;
		{awId, awAddr, awLen, awSize, awBurst} = {t.id, t.addr, t.len, t.size, t.burst};
		awValid = 1'b1;
		do @(posedge CLK); while (!awReady);
		#1 awValid = 1'b0;
		for (int i = 0; i < beats; i++) begin
			data = $random(seed);
			{wData, wStrb, wLast, wValid} = {data, t.strb, i == beats - 1, 1'b1};
			do @(posedge CLK); while (!wReady);
			if (t.resp == OKAY) begin	// Error bursts leave memory alone
				for (int b = 0; b < `AXI_DATA_W / 8; b++)
					if (t.strb[b])
						refMem[wordOf(addr)][8*b +: 8] = data[8*b +: 8];
			end
			addr = stepAddr(addr, t.burst);
			#1;
		end
		{wValid, wLast} = 2'b00;
		stalled = 1'b0;
		done = 1'b0;
		bReady = coinFlip();
		while (!done) begin
			@(posedge CLK);
			if (stalled && !bValid)
				reportProblem({t.name, ": BVALID dropped before BREADY"});
			stalled = bValid && !bReady;
			if (bValid && bReady) begin
				checkId({t.name, " BID"}, t.id, bId);
				checkResp({t.name, " BRESP"}, t.resp, bResp);
				done = 1'b1;
			end
			#1 bReady = coinFlip();
		end
	endtask

	// ------------------------------------------------------------
	// Read burst: AR, then every R beat under random RREADY
	// ------------------------------------------------------------
	task automatic runRead(input testRow_t t);
		axiAddr_t	addr;
		axiData_t	exp;
		axiData_t	held;		// Payload seen while stalled
		int			beats;
		int			beat;
		logic		stalled;
		addr = t.addr;
		beats = int'(t.len) + 1;
		{arId, arAddr, arLen, arSize, arBurst} = {t.id, t.addr, t.len, t.size, t.burst};
		arValid = 1'b1;
		do @(posedge CLK); while (!arReady);
		#1 arValid = 1'b0;
		beat = 0;
		stalled = 1'b0;
		held = '0;
		rReady = coinFlip();
		while (beat < beats) begin
			@(posedge CLK);
			if (stalled && (!rValid || rData !== held))
				reportProblem({t.name, ": R beat changed or vanished while RREADY was low"});
			stalled = rValid && !rReady;
			held = rData;
			if (rValid && rReady) begin
				exp = (t.resp == OKAY) ? refMem[wordOf(addr)] : '0;	// Error beats read zero
				checkId({t.name, " RID"}, t.id, rId);
				checkResp({t.name, " RRESP"}, t.resp, rResp);
				checkData({t.name, $sformatf(" RDATA beat %0d", beat)}, exp, rData);
				checkLast({t.name, $sformatf(" RLAST beat %0d", beat)}, beat == beats - 1, rLast);
				addr = stepAddr(addr, t.burst);
				beat++;
			end
			#1 rReady = coinFlip();
		end
		@(posedge CLK);
		if (rValid)
			reportProblem({t.name, ": extra R beat after the last one"});
		#1;
	endtask

	// Ends a run that stops making progress
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= limit && limit != 0) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Test table and main sequence
	// ------------------------------------------------------------
	initial begin
		tests[0]  = '{"singleWrite", 1'b1, 4'h1, 32'h100,  8'd0,  INCR,  3'd2, 4'hF, OKAY};
		tests[1]  = '{"singleRead",  1'b0, 4'h2, 32'h100,  8'd0,  INCR,  3'd2, 4'hF, OKAY};
		tests[2]  = '{"incrWrite",   1'b1, 4'h3, 32'hFF0,  8'd15, INCR,  3'd2, 4'hF, OKAY};
		tests[3]  = '{"incrRead",    1'b0, 4'h4, 32'hFF8,  8'd7,  INCR,  3'd2, 4'hF, OKAY};
		tests[4]  = '{"strobeWrite", 1'b1, 4'h5, 32'h100,  8'd0,  INCR,  3'd2, 4'h5, OKAY};
		tests[5]  = '{"strobeRead",  1'b0, 4'h6, 32'h100,  8'd0,  INCR,  3'd2, 4'hF, OKAY};
		tests[6]  = '{"fixedWrite",  1'b1, 4'h7, 32'h300,  8'd3,  FIXED, 3'd2, 4'hF, OKAY};
		tests[7]  = '{"fixedRead",   1'b0, 4'h8, 32'h300,  8'd3,  FIXED, 3'd2, 4'hF, OKAY};
		tests[8]  = '{"wrapWrite",   1'b1, 4'h9, 32'h000,  8'd3,  WRAP,  3'd2, 4'hF, SLVERR};
		tests[9]  = '{"sizeRead",    1'b0, 4'hA, 32'h004,  8'd1,  INCR,  3'd1, 4'hF, SLVERR};
		tests[10] = '{"decodeWrite", 1'b1, 4'hB, 32'h1000, 8'd1,  INCR,  3'd2, 4'hF, DECERR};
		tests[11] = '{"longRead",    1'b0, 4'hC, 32'hFF0,  8'd15, INCR,  3'd2, 4'hF, OKAY};
		foreach (tests[i])
			limit += 8 * (int'(tests[i].len) + 1) + 20;

		{awId, awAddr, awLen, awSize, awBurst, awValid} = '0;
		{arId, arAddr, arLen, arSize, arBurst, arValid} = '0;
		{wData, wStrb, wLast, wValid} = '0;
		{bReady, rReady} = 2'b00;

		@(negedge reset);
		@(posedge CLK);
		if (awReady || wReady || arReady || bValid || rValid)
			reportProblem("A ready or valid output is high right after reset");
		#1;
		foreach (tests[i]) begin
			if (tests[i].isWrite)
				runWrite(tests[i]);
			else
				runRead(tests[i]);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* verif/clockGen.sv */
/* Testbench clock and reset source, period 10
   Reset stays high for the first 8 rising edges */
module clockGen #(
	parameter int halfPeriod	= 5,
	parameter int resetCycles	= 8
) (
	output	logic	CLK,
	output	logic	reset
);

	initial begin
		CLK = 1'b0;
		forever #halfPeriod CLK = ~CLK;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge CLK);
		#1 reset = 1'b0;	// Released just after an edge, like the other inputs
	end

endmodule
